// File: hdl/uncorePkg.sv
////////////////////////////////////////////////////////////
// One 32-bit AHB-Lite data path and word-aligned regions only
// Region sizes beyond the GPIO window come from uncore parameters
////////////////////////////////////////////////////////////
package uncorePkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] busAddr;
  typedef logic [31:0] busData;
  // One bit per byte lane
  typedef logic [3:0]  byteStrobe;

  // HTRANS encoding
  // Only NONSEQ and SEQ open an address phase
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransKind;

  // Decoded region of an address phase
  typedef enum logic [1:0] {
    NONE = 2'd0,
    RAM  = 2'd1,
    ROM  = 2'd2,
    GPIO = 2'd3
  } regionSel;

  // GPIO word offsets inside the 32-byte window
  typedef enum logic [2:0] {
    INVAL  = 3'd0,
    OUTVAL = 3'd1,
    OUTEN  = 3'd2,
    RISEIE = 3'd3,
    RISEIP = 3'd4
  } gpioReg;

  ////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////
  localparam busAddr RAM_BASE   = 32'h8000_0000;
  localparam busAddr ROM_BASE   = 32'h0000_1000;
  localparam busAddr GPIO_BASE  = 32'h1006_0000;
  localparam busAddr GPIO_BYTES = 32'd32;

  // Boot image word at a word index
  function automatic busData bootImage(input int unsigned idx);
    busData w;
    w = busData'(idx);
    return (w * 32'h9E37_79B9) ^ (w << 16);
  endfunction

endpackage

// File: hdl/addrDecoder.sv
////////////////////////////////////////////////////////////
// Pure combinational decode of the current address phase
// Idle transfers still decode an address but report active low
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module addrDecoder #(
  parameter int ramWords = 256,
  parameter int romWords = 64
) (
  input  uncorePkg::busAddr    HADDR,
  input  uncorePkg::htransKind HTRANS,
  output uncorePkg::regionSel  region,
  output logic                 active
);
  import uncorePkg::*;

  // Region sizes in bytes
  localparam busAddr ramBytes = busAddr'(ramWords * 4);
  localparam busAddr romBytes = busAddr'(romWords * 4);

  logic ramHit;
  logic romHit;
  logic gpioHit;

  ////////////////////////////////////////////////////////////
  // Range compares
  ////////////////////////////////////////////////////////////
  // Offset from the base wraps high for addresses below it
  // so one unsigned compare covers both ends of the range
  assign ramHit  = (HADDR - RAM_BASE) < ramBytes;
  assign romHit  = (HADDR - ROM_BASE) < romBytes;
  assign gpioHit = (HADDR - GPIO_BASE) < GPIO_BYTES;

  // Regions never overlap, order only matters for readability
  always_comb begin
    if (ramHit) begin
      region = RAM;
    end else if (romHit) begin
      region = ROM;
    end else if (gpioHit) begin
      region = GPIO;
    end else begin
      region = NONE;
    end
  end

  // A real transfer starts only on NONSEQ or SEQ
  // IDLE and BUSY never turn into an error response
  assign active = (HTRANS == NONSEQ) || (HTRANS == SEQ);

endmodule

// File: hdl/ramAhb.sv
////////////////////////////////////////////////////////////
// RAM slave with no wait states and byte lanes from HWSTRB
// ramWords should be a power of two, upper address bits ignored
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ramAhb #(
  parameter int ramWords = 256
) (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  logic                 sel,
  input  uncorePkg::busAddr    HADDR,
  input  logic                 HWRITE,
  input  logic                 HREADY,
  input  uncorePkg::busData    HWDATA,
  input  uncorePkg::byteStrobe HWSTRB,
  output uncorePkg::busData    rdata,
  output logic                 ready
);
  import uncorePkg::*;

  localparam int idxW = $clog2(ramWords);

  // Word array
  busData mem [ramWords];

  // Address phase captured for the data phase
  logic [idxW-1:0] idxD;
  logic            wrD;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////
  // Write flag only moves on an accepted address phase
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      wrD <= 1'b0;
    end else if (HREADY) begin
      wrD <= sel & HWRITE;
    end
  end

  // Word index of the selected transfer
  always_ff @(posedge HCLK) begin
    if (HREADY && sel) begin
      idxD <= HADDR[idxW+1:2];
    end
  end

  ////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////
  // HWDATA and HWSTRB sampled on the closing edge
  always_ff @(posedge HCLK) begin
    if (wrD && HREADY) begin
      for (int b = 0; b < 4; b++) begin
        if (HWSTRB[b]) begin
          mem[idxD][8*b +: 8] <= HWDATA[8*b +: 8];
        end
      end
    end
  end

  // Read straight from the array at the latched index
  // A write just before lands first so the next read sees it
  assign rdata = mem[idxD];

  // Every access finishes in its first data-phase cycle
  assign ready = 1'b1;

endmodule

// File: hdl/bootRom.sv
////////////////////////////////////////////////////////////
// Boot ROM with one wait state per read and a registered word
// Writes are refused with an error and leave the image intact
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bootRom #(
  parameter int romWords = 64
) (
  input  logic              HCLK,
  input  logic              rstN,
  input  logic              sel,
  input  uncorePkg::busAddr HADDR,
  input  logic              HWRITE,
  input  logic              HREADY,
  output uncorePkg::busData rdata,
  output logic              ready,
  output logic              resp
);
  import uncorePkg::*;

  localparam int idxW = $clog2(romWords);

  // DONE doubles as the idle state
  typedef enum logic {
    WAIT,
    DONE
  } romState;

  romState         state;
  busData          romMem [romWords];
  busData          dataQ;
  logic [idxW-1:0] idxD;
  logic            errD;

  // Image fixed at elaboration
  for (genvar i = 0; i < romWords; i++) begin : gImage
    assign romMem[i] = bootImage(i);
  end

  ////////////////////////////////////////////////////////////
  // Read FSM and write error
  ////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      state <= DONE;
      errD  <= 1'b0;
    end else begin
      case (state)
        DONE: begin
          if (HREADY && sel && !HWRITE) begin
            state <= WAIT;
          end
        end
        WAIT: state <= DONE;
        default: state <= DONE;
      endcase
      // Error flag for the data phase of a ROM write
      if (HREADY) begin
        errD <= sel & HWRITE;
      end
    end
  end

  // Index at the address phase, word out during the wait
  always_ff @(posedge HCLK) begin
    if (HREADY && sel) begin
      idxD <= HADDR[idxW+1:2];
    end
    if (state == WAIT) begin
      dataQ <= romMem[idxD];
    end
  end

  assign rdata = dataQ;
  assign ready = (state == DONE);
  assign resp  = errD;

endmodule

// File: hdl/gpioAhb.sv
////////////////////////////////////////////////////////////
// GPIO registers written as whole words, strobes not used
// Pin edges reach RISEIP three flops after the pin is sampled
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpioAhb (
  input  logic              HCLK,
  input  logic              rstN,
  input  logic              sel,
  input  uncorePkg::busAddr HADDR,
  input  logic              HWRITE,
  input  logic              HREADY,
  input  uncorePkg::busData HWDATA,
  input  uncorePkg::busData gpioPinsIn,
  output uncorePkg::busData rdata,
  output uncorePkg::busData gpioPinsOut,
  output uncorePkg::busData gpioPinsEn,
  output logic              gpioIntr
);
  import uncorePkg::*;

  // Interrupt enable and pending
  busData riseIe;
  busData riseIp;

  // Input synchronizer and edge history
  busData sync1;
  busData sync2;
  busData prevIn;
  busData rise;
  busData riseClr;

  // Latched address phase
  logic [2:0] regD;
  logic       wrD;
  logic       wrEn;

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      wrD <= 1'b0;
    end else if (HREADY) begin
      wrD <= sel & HWRITE;
    end
  end

  // Word offset in the 32-byte window
  always_ff @(posedge HCLK) begin
    if (HREADY && sel) begin
      regD <= HADDR[4:2];
    end
  end

  assign wrEn = wrD && HREADY;

  // Write-one-to-clear mask for the pending bits
  assign riseClr = (wrEn && regD == RISEIP) ? HWDATA : '0;

  ////////////////////////////////////////////////////////////
  // Pin side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      sync1  <= '0;
      sync2  <= '0;
      prevIn <= '0;
    end else begin
      sync1  <= gpioPinsIn;
      sync2  <= sync1;
      prevIn <= sync2;
    end
  end

  // Synchronized low to high
  assign rise = sync2 & ~prevIn;

  // Registers, pending and interrupt
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      gpioPinsOut <= '0;
      gpioPinsEn  <= '0;
      riseIe      <= '0;
      riseIp      <= '0;
      gpioIntr    <= 1'b0;
    end else begin
      if (wrEn) begin
        case (regD)
          OUTVAL: gpioPinsOut <= HWDATA;
          OUTEN:  gpioPinsEn  <= HWDATA;
          RISEIE: riseIe      <= HWDATA;
          default: ;
        endcase
      end
      // A new edge wins over a clear in the same cycle
      riseIp   <= (riseIp & ~riseClr) | rise;
      gpioIntr <= |(riseIp & riseIe);
    end
  end

  // Read mux, offsets past RISEIP give zero
  always_comb begin
    case (regD)
      INVAL:   rdata = sync2;
      OUTVAL:  rdata = gpioPinsOut;
      OUTEN:   rdata = gpioPinsEn;
      RISEIE:  rdata = riseIe;
      RISEIP:  rdata = riseIp;
      default: rdata = '0;
    endcase
  end

endmodule

// File: hdl/uncore.sv
////////////////////////////////////////////////////////////
// AHB-Lite slave side with RAM, boot ROM and GPIO on one bus
// Single master, unmapped addresses end in a one-cycle error
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uncore #(
  parameter int ramWords = 256,
  parameter int romWords = 64
) (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  uncorePkg::busAddr    HADDR,
  input  uncorePkg::busData    HWDATA,
  input  uncorePkg::byteStrobe HWSTRB,
  input  logic                 HWRITE,
  input  uncorePkg::htransKind HTRANS,
  // Transfer width travels on HWSTRB instead
  input  logic [2:0]           HSIZE,
  input  uncorePkg::busData    gpioPinsIn,
  output uncorePkg::busData    HRDATA,
  output logic                 HREADY,
  output logic                 HRESP,
  output uncorePkg::busData    gpioPinsOut,
  output uncorePkg::busData    gpioPinsEn,
  output logic                 gpioIntr
);
  import uncorePkg::*;

  regionSel region;
  regionSel regionD;
  logic     active;
  logic     activeD;
  logic     selRam;
  logic     selRom;
  logic     selGpio;
  busData   ramRdata;
  busData   romRdata;
  busData   gpioRdata;
  logic     ramReady;
  logic     romReady;
  logic     romResp;

  ////////////////////////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////////////////////////
  addrDecoder #(
    .ramWords(ramWords),
    .romWords(romWords)
  ) uDecoder (
    .HADDR,
    .HTRANS,
    .region,
    .active
  );

  // One select per slave, only for real transfers
  assign selRam  = active && (region == RAM);
  assign selRom  = active && (region == ROM);
  assign selGpio = active && (region == GPIO);

  ////////////////////////////////////////////////////////////
  // Slaves
  ////////////////////////////////////////////////////////////
  ramAhb #(.ramWords(ramWords)) uRam (
    .HCLK, .rstN, .sel(selRam), .HADDR, .HWRITE, .HREADY,
    .HWDATA, .HWSTRB, .rdata(ramRdata), .ready(ramReady)
  );

  bootRom #(.romWords(romWords)) uBootRom (
    .HCLK, .rstN, .sel(selRom), .HADDR, .HWRITE, .HREADY,
    .rdata(romRdata), .ready(romReady), .resp(romResp)
  );

  gpioAhb uGpio (
    .HCLK, .rstN, .sel(selGpio), .HADDR, .HWRITE, .HREADY, .HWDATA,
    .gpioPinsIn, .rdata(gpioRdata), .gpioPinsOut, .gpioPinsEn, .gpioIntr
  );

  // Data-phase owner, held while a wait state stretches HREADY low
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      regionD <= NONE;
      activeD <= 1'b0;
    end else if (HREADY) begin
      regionD <= region;
      activeD <= active;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////////////////////////
  always_comb begin
    HRDATA = '0;
    HREADY = 1'b1;
    HRESP  = 1'b0;
    if (activeD) begin
      case (regionD)
        RAM: begin
          HRDATA = ramRdata;
          HREADY = ramReady;
        end
        ROM: begin
          HRDATA = romRdata;
          HREADY = romReady;
          HRESP  = romResp;
        end
        GPIO: HRDATA = gpioRdata;
        // Nothing mapped there, error in one cycle keeps the bus alive
        default: HRESP = 1'b1;
      endcase
    end
  end

endmodule

// File: tests/clockGen.sv
////////////////////////////////////////////////////////////
// Free-running 20 ns HCLK with rstN held low for 16 edges
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clockGen (
  output logic HCLK,
  output logic rstN
);

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // Released on an edge so the DUT sees 16 reset edges
  initial begin
    rstN = 1'b0;
    repeat (16) @(posedge HCLK);
    rstN <= 1'b1;
  end

endmodule

// File: tests/uncoreChk.sv
////////////////////////////////////////////////////////////
// Bus response rules checked on every HCLK edge out of reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uncoreChk (
  input logic              HCLK,
  input logic              rstN,
  input logic              HREADY,
  input logic              HRESP,
  input logic              gpioIntr,
  input uncorePkg::busData riseIe
);

  // Failure count read back by the testbench
  int assertErrs = 0;

  // ROM is the only slave with a wait state and it has just one
  aOneWait: assert property (@(posedge HCLK) disable iff (!rstN)
    !HREADY |=> HREADY)
  else begin
    assertErrs++;
    $error("HREADY stayed low for two cycles");
  end

  // Single-cycle error response
  aRespReady: assert property (@(posedge HCLK) disable iff (!rstN)
    HRESP |-> HREADY)
  else begin
    assertErrs++;
    $error("HRESP high while HREADY low");
  end

  // Interrupt is registered so it may lag the enable by one edge
  aIntrEnable: assert property (@(posedge HCLK) disable iff (!rstN)
    (riseIe == '0) |=> !gpioIntr)
  else begin
    assertErrs++;
    $error("gpioIntr high with RISEIE zero");
  end

endmodule

bind uncore uncoreChk uChk (
  .HCLK, .rstN, .HREADY, .HRESP, .gpioIntr, .riseIe(uGpio.riseIe)
);

// File: tests/uncoreTb.sv
////////////////////////////////////////////////////////////
// Single master on the bus with a reference model of every slave
// Inputs move 2 ns after HCLK rises and outputs are read at the falling edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uncoreTb;
  import uncorePkg::*;

  localparam int ramWords   = 256;
  localparam int romWords   = 64;
  localparam int ramN       = 32;
  localparam int romN       = 16;
  localparam int badN       = 12;
  localparam int mixN       = 300;
  // Last term bounds the GPIO tests and the idle flushes
  localparam int totalXfers = ramWords + 2 * ramN + romN + badN + mixN + 120;
  localparam int driveDelay = 2;

  logic       HCLK;
  logic       rstN;
  busAddr     HADDR;
  busData     HWDATA;
  byteStrobe  HWSTRB;
  logic       HWRITE;
  htransKind  HTRANS;
  logic [2:0] HSIZE;
  busData     gpioPinsIn;
  busData     HRDATA;
  logic       HREADY;
  logic       HRESP;
  busData     gpioPinsOut;
  busData     gpioPinsEn;
  logic       gpioIntr;

  // Model state
  busData ramModel [ramWords];
  busData gOut;
  busData gEn;
  busData gIe;
  busData gIp;
  busData gPins;

  // Transfer in data phase
  logic      pendValid;
  logic      pendChk;
  logic      pendResp;
  logic      pendReady;
  busData    pendExp;
  busData    pendWdata;
  byteStrobe pendStrb;
  string     pendWhat;

  int errors;
  int checks;
  int errMark;
  int chkMark;

  clockGen uClock (.HCLK, .rstN);

  uncore #(.ramWords(ramWords), .romWords(romWords)) u_dut (
    .HCLK, .rstN, .HADDR, .HWDATA, .HWSTRB, .HWRITE, .HTRANS, .HSIZE, .gpioPinsIn,
    .HRDATA, .HREADY, .HRESP, .gpioPinsOut, .gpioPinsEn, .gpioIntr
  );

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic compareData(input busData got, input busData exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compareResp(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns: %s HRESP %b, expected %b", $time, what, got, exp);
    end
  endtask

  // HREADY in the first data-phase cycle
  task automatic compareReady(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns: %s HREADY %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic comparePins(input busData got, input busData exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  // Index times 9E3779B9 XOR the index moved up 16 bits
  function automatic busData romWord(input busData idx);
    return (idx * 32'h9E37_79B9) ^ (idx << 16);
  endfunction

  function automatic regionSel regionOf(input busAddr a);
    if (a >= RAM_BASE && a < RAM_BASE + ramWords * 4) return RAM;
    if (a >= ROM_BASE && a < ROM_BASE + romWords * 4) return ROM;
    if (a >= GPIO_BASE && a < GPIO_BASE + 32) return GPIO;
    return NONE;
  endfunction

  task automatic modelAccess(input busAddr a, input logic wr, input busData wd,
                             input byteStrobe strb, output logic chk,
                             output busData exp, output logic resp, output logic ready);
    busData idx;
    chk   = !wr;
    exp   = '0;
    resp  = 1'b0;
    ready = 1'b1;
    case (regionOf(a))
      RAM: begin
        idx = (a - RAM_BASE) >> 2;
        if (!wr) begin
          exp = ramModel[idx];
        end
        for (int b = 0; b < 4; b++) begin
          if (wr && strb[b]) begin
            ramModel[idx][8*b +: 8] = wd[8*b +: 8];
          end
        end
      end
      ROM: begin
        resp  = wr;
        // Reads wait one cycle for the registered word
        ready = wr;
        exp   = romWord((a - ROM_BASE) >> 2);
      end
      GPIO: begin
        if (wr) begin
          case (a[4:2])
            OUTVAL:  gOut = wd;
            OUTEN:   gEn = wd;
            RISEIE:  gIe = wd;
            RISEIP:  gIp = gIp & ~wd;
            default: ;
          endcase
        end else begin
          case (a[4:2])
            INVAL:   exp = gPins;
            OUTVAL:  exp = gOut;
            OUTEN:   exp = gEn;
            RISEIE:  exp = gIe;
            RISEIP:  exp = gIp;
            default: exp = '0;
          endcase
        end
      end
      // Unmapped gives an error with zero data either way
      default: begin
        chk  = 1'b1;
        resp = 1'b1;
      end
    endcase
  endtask

  // Rising pins turn pending once they clear the synchronizer
  task automatic setPins(input busData v);
    gIp        = gIp | (v & ~gPins);
    gPins      = v;
    gpioPinsIn = v;
  endtask

  ////////////////////////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////////////////////////
  // New address phase goes out while the previous one is in data phase
  task automatic transfer(input busAddr a, input htransKind trans, input logic wr,
                          input busData wd, input byteStrobe strb, input logic chk,
                          input busData exp, input logic resp, input logic ready,
                          input string what);
    logic   rdy;
    int     waits;
    busData gotData;
    logic   gotResp;
    HADDR  = a;
    HTRANS = trans;
    HWRITE = wr;
    HWDATA = pendWdata;
    HWSTRB = pendStrb;
    waits  = 0;
    // Address held until an edge with HREADY high
    do begin
      @(negedge HCLK);
      rdy     = HREADY;
      gotData = HRDATA;
      gotResp = HRESP;
      if (!rdy) begin
        waits++;
      end
      @(posedge HCLK);
      #driveDelay;
    end while (!rdy);
    if (pendValid) begin
      compareReady(waits == 0, pendReady, pendWhat);
      compareResp(gotResp, pendResp, pendWhat);
      if (pendChk) begin
        compareData(gotData, pendExp, pendWhat);
      end
    end
    pendValid = 1'b1;
    pendChk   = chk;
    pendExp   = exp;
    pendResp  = resp;
    pendReady = ready;
    pendWdata = wd;
    pendStrb  = strb;
    pendWhat  = what;
  endtask

  task automatic access(input busAddr a, input logic wr, input busData wd,
                        input byteStrobe strb, input htransKind trans, input string what);
    logic   chk;
    busData exp;
    logic   resp;
    logic   ready;
    modelAccess(a, wr, wd, strb, chk, exp, resp, ready);
    transfer(a, trans, wr, wd, strb, chk, exp, resp, ready, what);
  endtask

  task automatic idleCycle();
    transfer('0, IDLE, 1'b0, '0, '0, 1'b0, '0, 1'b0, 1'b1, "idle");
  endtask

  function automatic busAddr ramAddr();
    return RAM_BASE + 4 * ($urandom % ramWords);
  endfunction

  function automatic busAddr romAddr();
    return ROM_BASE + 4 * ($urandom % romWords);
  endfunction

  function automatic busAddr badAddr();
    busAddr a;
    do begin
      a = $urandom & 32'hFFFF_FFFC;
    end while (regionOf(a) != NONE);
    return a;
  endfunction

  task automatic finishTest(input string name);
    $display("Test %-6s %4d checks, %0d errors", name, checks - chkMark, errors - errMark);
    chkMark = checks;
    errMark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  initial begin
    busAddr      a;
    busData      pattern;
    busData      ie;
    int unsigned kind;
    htransKind   trans;
    logic        wr;
    void'($urandom(32'h18d9_f8ff));
    HADDR      = '0;
    HWDATA     = '0;
    HWSTRB     = '0;
    HWRITE     = 1'b0;
    HTRANS     = IDLE;
    HSIZE      = 3'b010;
    gpioPinsIn = '0;
    gOut       = '0;
    gEn        = '0;
    gIe        = '0;
    gIp        = '0;
    gPins      = '0;
    pendValid  = 1'b0;
    pendWdata  = '0;
    pendStrb   = '0;
    errors     = 0;
    checks     = 0;
    errMark    = 0;
    chkMark    = 0;
    wait (rstN);
    @(posedge HCLK);
    #driveDelay;

    // Fill every RAM word so later random reads have known data
    for (int i = 0; i < ramWords; i++) begin
      a = RAM_BASE + 4 * i;
      access(a, 1'b1, a ^ (a << 13) ^ 32'hA5C3_5A3C, 4'hF, NONSEQ, "ram fill");
    end
    repeat (ramN) access(ramAddr(), 1'b1, $urandom, byteStrobe'($urandom), NONSEQ, "ram write");
    repeat (ramN) access(ramAddr(), 1'b0, '0, '0, NONSEQ, "ram read");
    idleCycle();
    finishTest("ram");

    repeat (romN) access(romAddr(), 1'b0, '0, '0, NONSEQ, "rom read");
    a = romAddr();
    access(a, 1'b1, $urandom, 4'hF, NONSEQ, "rom write");
    access(a, 1'b0, '0, '0, NONSEQ, "rom read after write");
    idleCycle();
    finishTest("rom");

    repeat (badN) access(badAddr(), 1'($urandom), $urandom, 4'hF, NONSEQ, "unmapped");
    a = ramAddr();
    access(a, 1'b1, $urandom, 4'hF, NONSEQ, "ram write after error");
    access(a, 1'b0, '0, '0, NONSEQ, "ram read after error");
    idleCycle();
    finishTest("error");

    access(GPIO_BASE + 4 * OUTVAL, 1'b1, $urandom, 4'hF, NONSEQ, "outval write");
    access(GPIO_BASE + 4 * OUTEN, 1'b1, $urandom, 4'hF, NONSEQ, "outen write");
    idleCycle();
    comparePins(gpioPinsOut, gOut, "gpioPinsOut");
    comparePins(gpioPinsEn, gEn, "gpioPinsEn");
    // Three edges let the pins pass the synchronizer
    repeat (4) begin
      setPins($urandom);
      repeat (3) idleCycle();
      access(GPIO_BASE + 4 * INVAL, 1'b0, '0, '0, NONSEQ, "inval read");
    end
    idleCycle();
    finishTest("gpio");

    for (int r = 0; r < 2; r++) begin
      pattern = $urandom | 32'h1;
      // Round 0 enables some rising pins and round 1 only the others
      ie = (r == 0) ? ((pattern & $urandom) | (pattern & -pattern)) : ~pattern;
      setPins('0);
      repeat (3) idleCycle();
      access(GPIO_BASE + 4 * RISEIP, 1'b1, '1, 4'hF, NONSEQ, "riseip clear all");
      access(GPIO_BASE + 4 * RISEIE, 1'b1, ie, 4'hF, NONSEQ, "riseie write");
      idleCycle();
      setPins(pattern);
      repeat (4) idleCycle();
      comparePins(busData'(gpioIntr), busData'(|(pattern & ie)), "gpioIntr after edge");
      access(GPIO_BASE + 4 * RISEIP, 1'b0, '0, '0, NONSEQ, "riseip after edge");
      access(GPIO_BASE + 4 * RISEIP, 1'b1, pattern, 4'hF, NONSEQ, "riseip clear");
      repeat (2) idleCycle();
      comparePins(busData'(gpioIntr), '0, "gpioIntr after clear");
      access(GPIO_BASE + 4 * RISEIP, 1'b0, '0, '0, NONSEQ, "riseip after clear");
    end
    setPins('0);
    repeat (3) idleCycle();
    finishTest("edges");

    // Pins stay put here so INVAL and RISEIP are steady
    for (int n = 0; n < mixN; n++) begin
      kind  = $urandom % 8;
      trans = $urandom_range(1) ? SEQ : NONSEQ;
      wr    = 1'($urandom);
      case (kind)
        0, 1, 2: access(ramAddr(), wr, $urandom, byteStrobe'($urandom), trans, "mix ram");
        3:       access(romAddr(), wr, $urandom, 4'hF, trans, "mix rom");
        4, 5:    access(GPIO_BASE + 4 * ($urandom % 8), wr, $urandom, 4'hF, trans, "mix gpio");
        6:       access(badAddr(), wr, $urandom, 4'hF, trans, "mix unmapped");
        default: idleCycle();
      endcase
    end
    idleCycle();
    comparePins(gpioPinsOut, gOut, "gpioPinsOut after mix");
    comparePins(gpioPinsEn, gEn, "gpioPinsEn after mix");
    finishTest("mix");

    $display("Checks %0d, errors %0d, assertion failures %0d",
             checks, errors, u_dut.uChk.assertErrs);
    if (errors == 0 && u_dut.uChk.assertErrs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog allows 3 cycles per transfer plus 2 us for reset
  initial begin
    #(longint'(totalXfers) * 3 * 20 + 2000);
    $display("Timeout: the bus transfers did not finish in %0d ns", totalXfers * 60 + 2000);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: tb.f
hdl/uncorePkg.sv
hdl/addrDecoder.sv
hdl/ramAhb.sv
hdl/bootRom.sv
hdl/gpioAhb.sv
hdl/uncore.sv
tests/clockGen.sv
tests/uncoreChk.sv
tests/uncoreTb.sv

// File: Bender.yml
package:
  name: uncore

sources:
  # RTL in compile order
  - files:
      - hdl/uncorePkg.sv
      - hdl/addrDecoder.sv
      - hdl/ramAhb.sv
      - hdl/bootRom.sv
      - hdl/gpioAhb.sv
      - hdl/uncore.sv

  # Testbench, top module uncoreTb
  - target: test
    files:
      - tests/clockGen.sv
      - tests/uncoreChk.sv
      - tests/uncoreTb.sv
